// File: logic/mcu_rom_arbiter.sv
`timescale 1ns/1ps

module mcu_rom_arbiter (
  input  logic                    CLK2,
  input  logic                    rst_n,
  input  logic                    mcu_rrq,
  input  logic                    mcu_wrq,
  input  rom_bus_pkg::snes_addr_t mcu_addr,
  input  rom_bus_pkg::rom_word_t  rom_din,
  input  logic                    cycle_start,
  input  logic                    cycle_end,
  input  logic                    snes_cs_n,
  input  logic                    snes_dead,
  input  logic                    snes_revived,
  output logic                    mcu_rdy,
  output rom_bus_pkg::byte_t      mcu_rdata,
  output logic                    mcu_hit_rd,
  output logic                    mcu_hit_wr,
  output rom_bus_pkg::snes_addr_t mcu_rom_addr
);
  import rom_bus_pkg::*;

  arb_state_t state;
  delay_t     mem_delay;
  snes_addr_t addr_q;
  logic       rd_pend;
  logic       wr_pend;
  logic       free_strobe;
  logic       free_slot;

  ///////////////////////////////
  // Request handshake
  ///////////////////////////////

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu_rrq) begin
      rd_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (mcu_wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (state == ST_MCU_RD_END || state == ST_MCU_WR_END) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (mcu_rrq || mcu_wrq) begin
      addr_q <= mcu_addr;
    end
  end

  // SNES cycle that misses the cartridge leaves the bus free
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= cycle_start & snes_cs_n;
    end
  end

  assign free_slot = cycle_end | free_strobe;

  ///////////////////////////////
  // Access FSM
  ///////////////////////////////

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      mem_delay <= '0;
    end else if (snes_revived) begin
      state <= ST_IDLE;  // Abort, pending access retries
    end else begin
      case (state)
        ST_IDLE: begin
          if (free_slot || snes_dead) begin
            if (rd_pend) begin
              state     <= ST_MCU_RD_ADDR;
              mem_delay <= delay_t'(ROM_CYCLE_LEN);
            end else if (wr_pend) begin
              state     <= ST_MCU_WR_ADDR;
              mem_delay <= delay_t'(ROM_CYCLE_LEN);
            end
          end
        end
        ST_MCU_RD_ADDR: begin
          mem_delay <= mem_delay - 1'b1;
          if (mem_delay == '0) state <= ST_MCU_RD_END;
        end
        ST_MCU_WR_ADDR: begin
          mem_delay <= mem_delay - 1'b1;
          if (mem_delay == '0) state <= ST_MCU_WR_END;
        end
        default: state <= ST_IDLE;  // END states last one cycle
      endcase
    end
  end

  // Last sample of the read phase is the one returned
  always_ff @(posedge CLK2) begin
    if (state == ST_MCU_RD_ADDR) begin
      mcu_rdata <= addr_q[0] ? rom_din[7:0] : rom_din[15:8];
    end
  end

  assign mcu_hit_rd   = (state == ST_MCU_RD_ADDR);
  assign mcu_hit_wr   = (state == ST_MCU_WR_ADDR);
  assign mcu_rom_addr = addr_q;

  a_no_strobe_busy: assert property (@(posedge CLK2) disable iff (!rst_n)
    (mcu_rrq || mcu_wrq) |-> mcu_rdy);

  a_hit_exclusive: assert property (@(posedge CLK2) disable iff (!rst_n)
    !(mcu_hit_rd && mcu_hit_wr));

endmodule

// File: logic/rom_bus_pkg.sv
package rom_bus_pkg;

  ///////////////////////////////
  // Bus widths
  ///////////////////////////////

  typedef logic [23:0] snes_addr_t;  // SNES CPU address
  typedef logic [22:0] rom_addr_t;   // PSRAM word address
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] rom_word_t;   // PSRAM data, two lanes

  // Memory cycle countdown
  typedef logic [3:0]  delay_t;

  // Counts CLK2 cycles with CPU clock low
  typedef logic [17:0] dead_cnt_t;

  ///////////////////////////////
  // MCU access FSM
  ///////////////////////////////

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_MCU_RD_ADDR,
    ST_MCU_RD_END,
    ST_MCU_WR_ADDR,
    ST_MCU_WR_END
  } arb_state_t;

  ///////////////////////////////
  // Timing
  ///////////////////////////////

  localparam int ROM_CYCLE_LEN     = 7;     // Countdown start, 8 cycle phase
  localparam int SNES_DEAD_TIMEOUT = 1024;  // Short value for simulation
  localparam int SYNC_DEPTH        = 8;     // Control line history length
  localparam int ADDR_TAPS         = 6;

endpackage

// File: logic/rom_bus_top.sv
`timescale 1ns/1ps

module rom_bus_top (
  input  logic                    CLK2,
  input  logic                    rst_n,
  input  rom_bus_pkg::snes_addr_t snes_addr_pin,
  input  rom_bus_pkg::byte_t      snes_data_pin,
  input  logic                    snes_rd_pin,
  input  logic                    snes_wr_pin,
  input  logic                    snes_cpu_clk_pin,
  input  logic                    snes_cs_pin,
  input  logic                    mcu_rrq,
  input  logic                    mcu_wrq,
  input  rom_bus_pkg::snes_addr_t mcu_addr,
  input  rom_bus_pkg::byte_t      mcu_wdata,
  input  rom_bus_pkg::rom_word_t  rom_din,
  output logic                    mcu_rdy,
  output rom_bus_pkg::byte_t      mcu_rdata,
  output logic                    snes_dead,
  output rom_bus_pkg::rom_addr_t  rom_addr,
  output rom_bus_pkg::rom_word_t  rom_dout,
  output logic                    rom_dout_en,
  output logic                    rom_we_n,
  output logic                    rom_bhe_n,
  output logic                    rom_ble_n,
  output rom_bus_pkg::byte_t      snes_data_out,
  output logic                    snes_data_oe
);
  import rom_bus_pkg::*;

  snes_addr_t snes_addr;
  byte_t      snes_data_in;
  snes_addr_t mcu_rom_addr;
  logic       snes_rd_n;
  logic       snes_wr_n;
  logic       snes_cpu_clk;
  logic       cpu_clk_raw;
  logic       snes_cs_n;
  logic       cycle_start;
  logic       cycle_end;
  logic       snes_revived;
  logic       mcu_hit_rd;
  logic       mcu_hit_wr;

  snes_bus_sync snes_bus_sync_inst (
    .CLK2(CLK2), .rst_n(rst_n),
    .snes_addr_pin(snes_addr_pin), .snes_data_pin(snes_data_pin),
    .snes_rd_pin(snes_rd_pin), .snes_wr_pin(snes_wr_pin),
    .snes_cpu_clk_pin(snes_cpu_clk_pin), .snes_cs_pin(snes_cs_pin),
    .snes_addr(snes_addr), .snes_data_in(snes_data_in),
    .snes_rd_n(snes_rd_n), .snes_wr_n(snes_wr_n), .snes_cpu_clk(snes_cpu_clk),
    .cpu_clk_raw(cpu_clk_raw), .snes_cs_n(snes_cs_n),
    .rd_start(),  // No register peripherals in this core
    .cycle_start(cycle_start), .cycle_end(cycle_end)
  );

  snes_liveness snes_liveness_inst (
    .CLK2(CLK2), .rst_n(rst_n), .cpu_clk_raw(cpu_clk_raw),
    .snes_dead(snes_dead), .snes_revived(snes_revived)
  );

  mcu_rom_arbiter mcu_rom_arbiter_inst (
    .CLK2(CLK2), .rst_n(rst_n),
    .mcu_rrq(mcu_rrq), .mcu_wrq(mcu_wrq), .mcu_addr(mcu_addr), .rom_din(rom_din),
    .cycle_start(cycle_start), .cycle_end(cycle_end), .snes_cs_n(snes_cs_n),
    .snes_dead(snes_dead), .snes_revived(snes_revived),
    .mcu_rdy(mcu_rdy), .mcu_rdata(mcu_rdata),
    .mcu_hit_rd(mcu_hit_rd), .mcu_hit_wr(mcu_hit_wr), .mcu_rom_addr(mcu_rom_addr)
  );

  rom_port rom_port_inst (
    .mcu_hit_rd(mcu_hit_rd), .mcu_hit_wr(mcu_hit_wr),
    .mcu_rom_addr(mcu_rom_addr), .mcu_wdata(mcu_wdata),
    .snes_addr(snes_addr), .snes_data_in(snes_data_in),
    .snes_rd_n(snes_rd_n), .snes_wr_n(snes_wr_n),
    .snes_cpu_clk(snes_cpu_clk), .snes_cs_n(snes_cs_n), .rom_din(rom_din),
    .rom_addr(rom_addr), .rom_dout(rom_dout), .rom_dout_en(rom_dout_en),
    .rom_we_n(rom_we_n), .rom_bhe_n(rom_bhe_n), .rom_ble_n(rom_ble_n),
    .snes_data_out(snes_data_out), .snes_data_oe(snes_data_oe)
  );

endmodule

// File: logic/rom_port.sv
`timescale 1ns/1ps

module rom_port (
  input  logic                    mcu_hit_rd,
  input  logic                    mcu_hit_wr,
  input  rom_bus_pkg::snes_addr_t mcu_rom_addr,
  input  rom_bus_pkg::byte_t      mcu_wdata,
  input  rom_bus_pkg::snes_addr_t snes_addr,
  input  rom_bus_pkg::byte_t      snes_data_in,
  input  logic                    snes_rd_n,
  input  logic                    snes_wr_n,
  input  logic                    snes_cpu_clk,
  input  logic                    snes_cs_n,
  input  rom_bus_pkg::rom_word_t  rom_din,
  output rom_bus_pkg::rom_addr_t  rom_addr,
  output rom_bus_pkg::rom_word_t  rom_dout,
  output logic                    rom_dout_en,
  output logic                    rom_we_n,
  output logic                    rom_bhe_n,
  output logic                    rom_ble_n,
  output rom_bus_pkg::byte_t      snes_data_out,
  output logic                    snes_data_oe
);
  import rom_bus_pkg::*;

  logic  mcu_hit;
  logic  lane_lo;      // Address bit 0 set picks the low byte
  logic  snes_wr_hit;
  byte_t wr_byte;

  ///////////////////////////////
  // Address source
  ///////////////////////////////

  assign mcu_hit  = mcu_hit_rd | mcu_hit_wr;
  assign rom_addr = mcu_hit ? mcu_rom_addr[23:1] : snes_addr[23:1];
  assign lane_lo  = mcu_hit ? mcu_rom_addr[0] : snes_addr[0];

  assign rom_bhe_n = lane_lo;
  assign rom_ble_n = ~lane_lo;

  ///////////////////////////////
  // Write path
  ///////////////////////////////

  assign snes_wr_hit = ~snes_cs_n & snes_cpu_clk & ~snes_wr_n;

  // SNES write wins, arbiter keeps MCU out of SNES slots anyway
  assign wr_byte = snes_wr_hit ? snes_data_in : mcu_wdata;

  assign rom_we_n    = ~(snes_wr_hit | mcu_hit_wr);
  assign rom_dout_en = snes_wr_hit | mcu_hit_wr;
  assign rom_dout    = lane_lo ? {8'h00, wr_byte} : {wr_byte, 8'h00};

  // Read data back to the SNES
  assign snes_data_out = lane_lo ? rom_din[7:0] : rom_din[15:8];
  assign snes_data_oe  = ~snes_rd_n & ~snes_cs_n;

endmodule

// File: logic/snes_bus_sync.sv
`timescale 1ns/1ps

module snes_bus_sync (
  input  logic                    CLK2,
  input  logic                    rst_n,
  input  rom_bus_pkg::snes_addr_t snes_addr_pin,
  input  rom_bus_pkg::byte_t      snes_data_pin,
  input  logic                    snes_rd_pin,
  input  logic                    snes_wr_pin,
  input  logic                    snes_cpu_clk_pin,
  input  logic                    snes_cs_pin,
  output rom_bus_pkg::snes_addr_t snes_addr,
  output rom_bus_pkg::byte_t      snes_data_in,
  output logic                    snes_rd_n,
  output logic                    snes_wr_n,
  output logic                    snes_cpu_clk,
  output logic                    cpu_clk_raw,
  output logic                    snes_cs_n,
  output logic                    rd_start,
  output logic                    cycle_start,
  output logic                    cycle_end
);
  import rom_bus_pkg::*;

  logic [SYNC_DEPTH-1:0] rd_hist;
  logic [SYNC_DEPTH-1:0] wr_hist;
  logic [SYNC_DEPTH-1:0] clk_hist;
  logic [SYNC_DEPTH-1:0] cs_hist;

  snes_addr_t addr_tap [ADDR_TAPS];
  byte_t      data_tap [ADDR_TAPS-2];

  ///////////////////////////////
  // Control line histories
  ///////////////////////////////

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      rd_hist  <= '1;  // Strobes idle high
      wr_hist  <= '1;
      cs_hist  <= '1;
      clk_hist <= '0;
    end else begin
      rd_hist  <= {rd_hist[SYNC_DEPTH-2:0], snes_rd_pin};
      wr_hist  <= {wr_hist[SYNC_DEPTH-2:0], snes_wr_pin};
      cs_hist  <= {cs_hist[SYNC_DEPTH-2:0], snes_cs_pin};
      clk_hist <= {clk_hist[SYNC_DEPTH-2:0], snes_cpu_clk_pin};
    end
  end

  // Address and data sample chains
  always_ff @(posedge CLK2) begin
    addr_tap[0] <= snes_addr_pin;
    data_tap[0] <= snes_data_pin;
    for (int i = 1; i < ADDR_TAPS; i++) begin
      addr_tap[i] <= addr_tap[i-1];
    end
    for (int j = 1; j < ADDR_TAPS-2; j++) begin
      data_tap[j] <= data_tap[j-1];
    end
  end

  // Two-sample AND filters out single-cycle glitches
  assign snes_addr    = addr_tap[ADDR_TAPS-1] & addr_tap[ADDR_TAPS-2];
  assign snes_data_in = data_tap[ADDR_TAPS-3] & data_tap[ADDR_TAPS-4];
  assign snes_rd_n    = rd_hist[2] & rd_hist[1];
  assign snes_wr_n    = wr_hist[2] & wr_hist[1];
  assign snes_cs_n    = cs_hist[2] & cs_hist[1];
  assign snes_cpu_clk = clk_hist[2] & clk_hist[1];
  assign cpu_clk_raw  = clk_hist[1];

  ///////////////////////////////
  // Edge strobes
  ///////////////////////////////

  assign rd_start    = ((rd_hist[6:1] | rd_hist[7:2]) == 6'b111110);    // Read falls
  assign cycle_start = ((clk_hist[6:1] & clk_hist[7:2]) == 6'b000001);  // CPU clock rises
  assign cycle_end   = ((clk_hist[6:1] | clk_hist[7:2]) == 6'b111110);  // CPU clock falls

  a_cycle_edges_apart: assert property (@(posedge CLK2) disable iff (!rst_n)
    !(cycle_start && cycle_end));

endmodule

// File: logic/snes_liveness.sv
`timescale 1ns/1ps

module snes_liveness (
  input  logic CLK2,
  input  logic rst_n,
  input  logic cpu_clk_raw,
  output logic snes_dead,
  output logic snes_revived
);
  import rom_bus_pkg::*;

  dead_cnt_t dead_cnt;

  // Time spent with the CPU clock low
  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      dead_cnt <= '0;
    end else if (cpu_clk_raw) begin
      dead_cnt <= '0;
    end else begin
      dead_cnt <= dead_cnt + 1'b1;
    end
  end

  ///////////////////////////////
  // Dead flag and revival strobe
  ///////////////////////////////

  always_ff @(posedge CLK2 or negedge rst_n) begin
    if (!rst_n) begin
      snes_dead    <= 1'b1;  // No SNES until a clock is seen
      snes_revived <= 1'b0;
    end else if (cpu_clk_raw) begin
      snes_dead    <= 1'b0;
      snes_revived <= snes_dead;  // First high cycle after dead
    end else begin
      snes_revived <= 1'b0;
      if (dead_cnt > dead_cnt_t'(SNES_DEAD_TIMEOUT)) begin
        snes_dead <= 1'b1;
      end
    end
  end

  a_revived_single: assert property (@(posedge CLK2) disable iff (!rst_n)
    snes_revived |=> !snes_revived);

endmodule

// File: sim.f
logic/rom_bus_pkg.sv
logic/snes_bus_sync.sv
logic/snes_liveness.sv
logic/mcu_rom_arbiter.sv
logic/rom_port.sv
logic/rom_bus_top.sv
verification/rom_bus_tb.sv

// File: verification/rom_bus_tb.sv
`timescale 1ns/1ps

module rom_bus_tb;
  import rom_bus_pkg::*;

  logic       CLK2 = 1'b0;
  logic       rst_n;
  snes_addr_t snes_addr_pin;
  byte_t      snes_data_pin;
  logic       snes_rd_pin;
  logic       snes_wr_pin;
  logic       snes_cpu_clk_pin;
  logic       snes_cs_pin;
  logic       mcu_rrq;
  logic       mcu_wrq;
  snes_addr_t mcu_addr;
  byte_t      mcu_wdata;
  rom_word_t  rom_din;
  logic       mcu_rdy;
  byte_t      mcu_rdata;
  logic       snes_dead;
  rom_addr_t  rom_addr;
  rom_word_t  rom_dout;
  logic       rom_dout_en;
  logic       rom_we_n;
  logic       rom_bhe_n;
  logic       rom_ble_n;
  byte_t      snes_data_out;
  logic       snes_data_oe;

  integer     seed;
  int         mismatch_cnt;
  int         timeout_cnt;
  int         other_cnt;
  logic       mcu_done;

  rom_word_t  psram [512];     // Words of the test window
  byte_t      ref_mem [1024];  // Expected byte per window address
  rom_addr_t  wr_addr_q;
  rom_word_t  wr_dout_q;
  logic       wr_bhe_q;
  logic       wr_ble_q;
  logic       wr_valid;

  rom_bus_top rom_bus_top_inst (.*);

  always #20 CLK2 = ~CLK2;

  // Test window sits at a fixed 1 KB block of the SNES space
  function automatic snes_addr_t win_addr(input logic [9:0] offs);
    return {14'h2a5d, offs};
  endfunction

  function automatic byte_t fill_byte(input snes_addr_t a);
    return a[23:16] ^ a[15:8] ^ {a[6:0], a[7]} ^ 8'h3c;
  endfunction

  // High byte holds the even address
  function automatic rom_word_t read_word(input rom_addr_t w);
    if (w[22:9] == 14'h2a5d) return psram[w[8:0]];
    return {fill_byte({w, 1'b0}), fill_byte({w, 1'b1})};
  endfunction

  //////////////////////////////
  // PSRAM model
  //////////////////////////////

  always @(posedge CLK2) begin
    rom_din <= read_word(rom_addr);
  end

  // Write lines are taken mid-cycle and stored when WE rises
  always @(negedge CLK2) begin
    if (rom_we_n === 1'b0) begin
      wr_addr_q = rom_addr;
      wr_dout_q = rom_dout;
      wr_bhe_q  = rom_bhe_n;
      wr_ble_q  = rom_ble_n;
      wr_valid  = 1'b1;
    end
  end

  always @(posedge rom_we_n) begin
    if (wr_valid) begin
      if (wr_addr_q[22:9] != 14'h2a5d) begin
        other_cnt++;
        $display("Write at %0t ns went outside the test window", $time);
      end else begin
        psram[wr_addr_q[8:0]] <= {
          wr_bhe_q ? psram[wr_addr_q[8:0]][15:8] : wr_dout_q[15:8],
          wr_ble_q ? psram[wr_addr_q[8:0]][7:0] : wr_dout_q[7:0]};
      end
      wr_valid = 1'b0;
    end
  end

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input rom_addr_t got, input rom_addr_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("Mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  // One MCU strobe and the wait for ready
  task automatic mcu_access(input logic is_wr, input snes_addr_t a, input byte_t d);
    int n;
    int wr_cycles;
    n = 0;
    wr_cycles = 0;
    @(posedge CLK2);
    mcu_addr  <= a;
    mcu_wdata <= d;
    mcu_wrq   <= is_wr;
    mcu_rrq   <= ~is_wr;
    @(posedge CLK2);
    mcu_rrq <= 1'b0;
    mcu_wrq <= 1'b0;
    @(negedge CLK2);
    while (mcu_rdy !== 1'b1 && n < 200) begin
      if (is_wr && rom_dout_en === 1'b1) begin  // MCU write phase
        wr_cycles++;
        check_addr("rom_addr", rom_addr, a[23:1]);
        check_bit("rom_bhe_n", rom_bhe_n, a[0]);
        check_bit("rom_ble_n", rom_ble_n, ~a[0]);
        check_bit("rom_we_n", rom_we_n, 1'b0);
        check_byte("rom_dout lane", a[0] ? rom_dout[7:0] : rom_dout[15:8], d);
      end
      n++;
      @(negedge CLK2);
    end
    if (mcu_rdy !== 1'b1) begin
      timeout_cnt++;
      $display("Timeout at %0t ns: MCU access to %h never finished", $time, a);
    end else if (is_wr) begin
      ref_mem[a[9:0]] = d;
      if (wr_cycles != ROM_CYCLE_LEN + 1) begin
        other_cnt++;
        $display("MCU write to %h drove the bus for %0d cycles", a, wr_cycles);
      end
    end else begin
      check_byte("mcu_rdata", mcu_rdata, ref_mem[a[9:0]]);
    end
  endtask

  // Kind 0 misses the cartridge while 1 reads a ROM hit and 2 writes one
  task automatic snes_cycle(input int kind, input snes_addr_t a, input byte_t d);
    integer r;
    int     lo_len;
    int     hi_len;
    r = $random(seed);
    lo_len = 16 + r[2:0];
    hi_len = 16 + r[5:3];
    @(posedge CLK2);
    snes_cpu_clk_pin <= 1'b0;
    snes_cs_pin      <= 1'b1;
    snes_rd_pin      <= 1'b1;
    snes_wr_pin      <= 1'b1;
    repeat (4) @(posedge CLK2);
    snes_addr_pin <= a;
    snes_data_pin <= d;
    snes_cs_pin   <= (kind == 0);
    snes_rd_pin   <= (kind != 1);
    snes_wr_pin   <= (kind != 2);
    repeat (lo_len - 4) @(posedge CLK2);
    snes_cpu_clk_pin <= 1'b1;
    repeat (hi_len - 1) @(posedge CLK2);
    @(negedge CLK2);  // Last cycle of the high phase
    check_bit("snes_data_oe", snes_data_oe, kind == 1);
    check_bit("rom_we_n", rom_we_n, kind != 2);
    check_bit("rom_dout_en", rom_dout_en, kind == 2);
    if (kind == 1) begin
      check_byte("snes_data_out", snes_data_out, ref_mem[a[9:0]]);
    end
    if (kind == 2) begin
      check_byte("rom_dout lane", a[0] ? rom_dout[7:0] : rom_dout[15:8], d);
      ref_mem[a[9:0]] = d;
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin : main_seq
    int         i;
    int         n;
    integer     r;
    snes_addr_t addrs [16];
    seed             = 32'h1fdf_5e25;
    mismatch_cnt     = 0;
    timeout_cnt      = 0;
    other_cnt        = 0;
    mcu_done         = 1'b0;
    wr_valid         = 1'b0;
    rst_n            = 1'b0;
    snes_addr_pin    = win_addr(10'h000);
    snes_data_pin    = '0;
    snes_rd_pin      = 1'b1;
    snes_wr_pin      = 1'b1;
    snes_cpu_clk_pin = 1'b0;  // SNES starts powered down
    snes_cs_pin      = 1'b1;
    mcu_rrq          = 1'b0;
    mcu_wrq          = 1'b0;
    mcu_addr         = '0;
    mcu_wdata        = '0;
    rom_din          = '0;
    for (i = 0; i < 1024; i++) begin
      ref_mem[i] = fill_byte(win_addr(i[9:0]));
    end
    for (i = 0; i < 512; i++) begin
      psram[i] = {fill_byte(win_addr({i[8:0], 1'b0})), fill_byte(win_addr({i[8:0], 1'b1}))};
    end

    repeat (3) @(posedge CLK2);
    rst_n <= 1'b1;
    @(negedge CLK2);
    check_bit("mcu_rdy", mcu_rdy, 1'b1);
    check_bit("rom_we_n", rom_we_n, 1'b1);
    check_bit("rom_dout_en", rom_dout_en, 1'b0);
    check_bit("snes_data_oe", snes_data_oe, 1'b0);
    check_bit("snes_dead", snes_dead, 1'b1);

    // MCU writes and reads both lanes while the SNES is dead
    for (i = 0; i < 16; i++) begin
      r = $random(seed);
      addrs[i] = win_addr({1'b0, r[7:0], i[0]});
      mcu_access(1'b1, addrs[i], r[15:8]);
    end
    for (i = 0; i < 16; i++) begin
      mcu_access(1'b0, addrs[i], 8'h00);
    end

    // SNES traffic with MCU reads slotted in
    fork
      begin : snes_traffic
        int     cnt;
        integer rs;
        cnt = 0;
        while ((!mcu_done || cnt < 24) && cnt < 80) begin
          rs = $random(seed);
          if (rs[1:0] == 2'b11) begin
            snes_cycle(2, win_addr({1'b1, rs[10:2]}), rs[18:11]);
          end else begin
            snes_cycle(rs[1:0] == 2'b00 ? 0 : 1, win_addr(rs[11:2]), rs[19:12]);
          end
          cnt++;
        end
      end
      begin : mcu_traffic
        int     j;
        integer rm;
        for (j = 0; j < 12; j++) begin
          rm = $random(seed);
          repeat (rm[3:0]) @(posedge CLK2);
          mcu_access(1'b0, win_addr({1'b0, rm[12:4]}), 8'h00);
        end
        mcu_done = 1'b1;
      end
    join

    // CPU clock stops and comes back
    @(posedge CLK2);
    snes_cpu_clk_pin <= 1'b0;
    snes_cs_pin      <= 1'b1;
    snes_rd_pin      <= 1'b1;
    snes_wr_pin      <= 1'b1;
    n = 0;
    @(negedge CLK2);
    while (snes_dead !== 1'b1 && n < SNES_DEAD_TIMEOUT + 64) begin
      n++;
      @(negedge CLK2);
    end
    if (snes_dead !== 1'b1) begin
      timeout_cnt++;
      $display("Timeout at %0t ns: snes_dead never rose with the clock stopped", $time);
    end else if (n < SNES_DEAD_TIMEOUT) begin
      other_cnt++;
      $display("snes_dead rose after only %0d cycles without a CPU clock", n);
    end
    @(posedge CLK2);
    snes_cpu_clk_pin <= 1'b1;
    n = 0;
    @(negedge CLK2);
    while (snes_dead !== 1'b0 && n < 16) begin
      n++;
      @(negedge CLK2);
    end
    if (snes_dead !== 1'b0) begin
      timeout_cnt++;
      $display("Timeout at %0t ns: snes_dead stayed high after the clock returned", $time);
    end

    $display("Errors: %0d mismatches, %0d timeouts, %0d other failures",
             mismatch_cnt, timeout_cnt, other_cnt);
    if (mismatch_cnt + timeout_cnt + other_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
